//--- common/msgPkg.sv
package msgPkg;

  // every stream word is one 32 bit word
  localparam int wordWidth = 32;

  // shift register depth of each FIFO as log2 and as word count
  localparam int fifoL2Depth = 5;
  localparam int fifoDepth   = 2 ** fifoL2Depth;

  // operation that asks for a checksum word after the payload
  localparam logic [7:0] opSum = 8'd1;

  // sum messages grow by one word so len must stay below 255
  localparam int maxSumLen = 254;

  // framer sequencer states
  localparam logic [1:0] stWaitHdr = 2'd0;  // next input word is a header
  localparam logic [1:0] stPayload = 2'd1;  // copying payload words
  localparam logic [1:0] stEmitSum = 2'd2;  // checksum word pending

  // header layout from msb to lsb
  typedef struct packed {
    logic [15:0] tag;  // opaque to the queue
    logic [7:0]  op;   // operation code
    logic [7:0]  len;  // payload words after this header
  } msgHeader_t;

  // a stream word seen as header or as raw payload
  typedef union packed {
    msgHeader_t             hdr;
    logic [wordWidth-1:0]   data;
  } msgWord_t;

endpackage

//--- fifo/srlFifoD.sv
`timescale 1ns/100ps

// shift register FIFO with a one word output register in front of the reader
module srlFifoD (
  input  logic             CLK,
  input  logic             reset,
  input  logic             clr,    // synchronous flush
  input  logic             enq,
  input  logic             deq,
  input  msgPkg::msgWord_t dIn,
  output msgPkg::msgWord_t dOut,
  output logic             fullN,
  output logic             emptyN
);

  msgPkg::msgWord_t                 srl [msgPkg::fifoDepth];  // new words enter at srl[0]
  msgPkg::msgWord_t                 dReg;      // registered output word
  logic [msgPkg::fifoL2Depth:0]     pos;       // words held in srl
  logic [msgPkg::fifoL2Depth:0]     posNext;
  logic [msgPkg::fifoL2Depth-1:0]   headIdx;   // oldest word in srl
  logic                             sEmpty;    // srl holds nothing
  logic                             sFull;     // srl holds fifoDepth words
  logic                             dEmpty;    // output register holds nothing
  logic                             srlToReg;  // move oldest srl word into dReg

  // refill the output register when it is empty or being read out
  assign srlToReg = !sEmpty && (dEmpty || deq);

  // pos is never 0 when the head is read, and 32 wraps to index 31
  assign headIdx = pos[msgPkg::fifoL2Depth-1:0] - 1'b1;

  always_comb begin
    posNext = pos;
    if (enq && !srlToReg) begin
      posNext = pos + 1'b1;   // grow
    end else if (!enq && srlToReg) begin
      posNext = pos - 1'b1;   // shrink
    end
  end

  // control state
  always_ff @(posedge CLK) begin
    if (reset || clr) begin
      pos    <= '0;
      sEmpty <= 1'b1;
      sFull  <= 1'b0;
      dEmpty <= 1'b1;
    end else begin
      pos    <= posNext;
      sEmpty <= (posNext == '0);                 // flags look one cycle ahead
      sFull  <= (posNext == msgPkg::fifoDepth);
      if (srlToReg) begin
        dEmpty <= 1'b0;
      end else if (deq) begin
        dEmpty <= 1'b1;   // read out with nothing behind it
      end
    end
  end

  // storage
  always_ff @(posedge CLK) begin
    if (enq) begin
      for (int i = msgPkg::fifoDepth - 1; i > 0; i--) begin
        srl[i] <= srl[i-1];
      end
      srl[0] <= dIn;
    end
    if (srlToReg) dReg <= srl[headIdx];  // reads the pre-shift array
  end

  assign dOut   = dReg;
  assign fullN  = !sFull;
  assign emptyN = !dEmpty;

  // writer and reader must honor the registered flags
  enqWhileFull: assert property (@(posedge CLK) disable iff (reset || clr) enq |-> fullN)
    else $error("srlFifoD enq while full");

  deqWhileEmpty: assert property (@(posedge CLK) disable iff (reset || clr) deq |-> emptyN)
    else $error("srlFifoD deq while empty");

endmodule

//--- source/msgFramer.sv
`timescale 1ns/100ps

// copies messages from the input FIFO to the output FIFO
// sum messages get len+1 in the header and a trailing checksum word
module msgFramer (
  input  logic             CLK,
  input  logic             reset,
  input  logic             clr,
  input  msgPkg::msgWord_t inWord,    // head of input FIFO
  input  logic             inEmptyN,
  output logic             inDeq,
  output msgPkg::msgWord_t outWord,   // word written to output FIFO
  input  logic             outFullN,
  output logic             outEnq
);

  logic [1:0]                    state;
  logic [1:0]                    stateNext;
  logic [7:0]                    remain;    // payload words still to copy
  logic                          isSum;     // current message gets a checksum
  logic [msgPkg::wordWidth-1:0]  sum;       // running payload sum mod 2^32
  logic                          hdrIsSum;  // header view says sum operation
  logic                          xfer;      // a word can cross this cycle

  assign hdrIsSum = (inWord.hdr.op == msgPkg::opSum);

  // a word moves only when there is one to take and room to put it
  assign xfer = inEmptyN && outFullN;

  // no input read while the checksum is being emitted
  assign inDeq  = (state != msgPkg::stEmitSum) && xfer;
  assign outEnq = (state == msgPkg::stEmitSum) ? outFullN : xfer;

  // output word in the same cycle as the input read
  always_comb begin
    outWord = inWord;   // payload and pass-through headers unchanged
    case (state)
      msgPkg::stWaitHdr: begin
        if (hdrIsSum) begin
          outWord.hdr.len = inWord.hdr.len + 8'd1;  // count the checksum word
        end
      end
      msgPkg::stEmitSum: begin
        outWord.data = sum;
      end
      default: begin
        outWord = inWord;
      end
    endcase
  end

  // sequencer
  always_comb begin
    stateNext = state;
    case (state)
      msgPkg::stWaitHdr: begin
        if (xfer) begin
          if (inWord.hdr.len != 8'd0) begin
            stateNext = msgPkg::stPayload;
          end else if (hdrIsSum) begin
            stateNext = msgPkg::stEmitSum;   // empty sum message still gets a zero sum
          end
        end
      end
      msgPkg::stPayload: begin
        if (xfer && remain == 8'd1) begin   // last payload word
          stateNext = isSum ? msgPkg::stEmitSum : msgPkg::stWaitHdr;
        end
      end
      msgPkg::stEmitSum: begin
        if (outFullN) stateNext = msgPkg::stWaitHdr;
      end
      default: begin
        stateNext = msgPkg::stWaitHdr;   // unused code recovers
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset || clr) begin
      state <= msgPkg::stWaitHdr;
    end else begin
      state <= stateNext;
    end
  end

  // per message counters loaded from every header
  always_ff @(posedge CLK) begin
    if (state == msgPkg::stWaitHdr && xfer) begin
      remain <= inWord.hdr.len;
      isSum  <= hdrIsSum;
      sum    <= '0;
    end else if (state == msgPkg::stPayload && xfer) begin
      remain <= remain - 8'd1;
      sum    <= sum + inWord.data;   // wraps mod 2^32
    end
  end

  // the producer must keep sum messages short enough for len+1 to fit
  sumLenLimit: assert property (@(posedge CLK) disable iff (reset || clr)
      (state == msgPkg::stWaitHdr && inDeq && hdrIsSum)
      |-> (inWord.hdr.len <= msgPkg::maxSumLen))
    else $error("msgFramer sum message longer than maxSumLen");

endmodule

//--- source/msgQueueTop.sv
`timescale 1ns/100ps

// producer -> input FIFO -> framer -> output FIFO -> consumer
module msgQueueTop (
  input  logic             CLK,
  input  logic             reset,
  input  logic             clr,      // flushes both FIFOs and the framer
  input  logic             enq,      // producer side
  input  msgPkg::msgWord_t dIn,
  output logic             fullN,
  input  logic             deq,      // consumer side
  output msgPkg::msgWord_t dOut,
  output logic             emptyN
);

  msgPkg::msgWord_t  inWord;     // input FIFO head
  logic              inEmptyN;
  logic              inDeq;
  msgPkg::msgWord_t  outWord;    // framed word into output FIFO
  logic              outEnq;
  logic              outFullN;

  // producer writes here, fullN back-pressures the producer
  srlFifoD u_inFifo (
    .CLK    (CLK),
    .reset  (reset),
    .clr    (clr),
    .enq    (enq),
    .deq    (inDeq),
    .dIn    (dIn),
    .dOut   (inWord),
    .fullN  (fullN),
    .emptyN (inEmptyN)
  );

  // stalls on empty input or full output
  msgFramer u_framer (
    .CLK      (CLK),
    .reset    (reset),
    .clr      (clr),
    .inWord   (inWord),
    .inEmptyN (inEmptyN),
    .inDeq    (inDeq),
    .outWord  (outWord),
    .outFullN (outFullN),
    .outEnq   (outEnq)
  );

  // consumer reads here
  srlFifoD u_outFifo (
    .CLK    (CLK),
    .reset  (reset),
    .clr    (clr),
    .enq    (outEnq),
    .deq    (deq),
    .dIn    (outWord),
    .dOut   (dOut),
    .fullN  (outFullN),
    .emptyN (emptyN)
  );

endmodule

//--- verification/clockGen.sv
`timescale 1ns/100ps

// free running testbench clock with a power-on reset
module clockGen (
  output logic CLK,
  output logic reset
);

  localparam int halfPeriod  = 50;  // 100 ns period
  localparam int resetCycles = 8;

  initial begin
    CLK = 1'b0;
    forever #halfPeriod CLK = ~CLK;
  end

  // reset drops on a falling edge like every other stimulus
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;
  end

endmodule

//--- verification/msgChecker.sv
`timescale 1ns/100ps

// watches both ends of the queue and compares output words with the reference
module msgChecker (
  input  logic             CLK,
  input  logic             reset,
  input  logic             clr,
  input  logic             enq,
  input  msgPkg::msgWord_t dIn,
  input  logic             fullN,
  input  logic             deq,
  input  msgPkg::msgWord_t dOut,
  input  logic             emptyN,
  input  logic             testEnd,
  input  logic [2:0]       testId,
  input  logic             stimFault,
  output int               errCount,
  output int               testsRun,
  output int               testsFailed
);

  logic [31:0] inMsg[$];   // words of the message being written
  logic [31:0] expQ[$];    // expected output words in order
  logic [31:0] actQ[$];    // output words waiting for their expected value
  int          testErrs;   // errors in the running test
  logic        clrSeen;    // flags get checked one edge after clr

  function automatic string testName(input logic [2:0] id);
    case (id)
      3'd1:    return "passThru";
      3'd2:    return "sumFrame";
      3'd3:    return "backPressure";
      3'd4:    return "mixedRandom";
      3'd5:    return "clearMidMsg";
      default: return "none";
    endcase
  endfunction

  // framing rule applied to the complete message held in inMsg
  function automatic void expectMsg();
    msgPkg::msgWord_t hdr;
    logic [31:0]      sum;
    hdr.data = inMsg[0];
    sum      = '0;
    if (hdr.hdr.op == msgPkg::opSum) begin
      hdr.hdr.len = hdr.hdr.len + 8'd1;   // checksum word counts as payload
      expQ.push_back(hdr.data);
      for (int k = 1; k < inMsg.size(); k++) begin
        sum = sum + inMsg[k];   // wraps mod 2^32
        expQ.push_back(inMsg[k]);
      end
      expQ.push_back(sum);
    end else begin
      for (int k = 0; k < inMsg.size(); k++) expQ.push_back(inMsg[k]);
    end
  endfunction

  task automatic addError();
    errCount++;
    testErrs++;
  endtask

  always @(posedge CLK) begin : watch
    msgPkg::msgWord_t hdr;
    logic [31:0]      want;
    logic [31:0]      got;
    if (reset) begin
      inMsg.delete();
      expQ.delete();
      actQ.delete();
      clrSeen     = 1'b0;
      testErrs    = 0;
      errCount    = 0;
      testsRun    = 0;
      testsFailed = 0;
    end else begin
      if (clrSeen) begin
        if (emptyN || !fullN) begin
          $display("test %s: queue not empty and ready after clear (emptyN=%b fullN=%b)",
                   testName(testId), emptyN, fullN);
          addError();
        end
        clrSeen = 1'b0;
      end

      if (clr) begin
        inMsg.delete();   // everything in flight is gone
        expQ.delete();
        actQ.delete();
        clrSeen = 1'b1;
      end else begin
        // a producer message is complete after len payload words
        if (enq && fullN) begin
          inMsg.push_back(dIn.data);
          hdr.data = inMsg[0];
          if (inMsg.size() == int'(hdr.hdr.len) + 1) begin
            expectMsg();
            inMsg.delete();
          end
        end
        // a header can leave the queue before its message is fully written
        if (deq && emptyN) actQ.push_back(dOut.data);
        while (expQ.size() != 0 && actQ.size() != 0) begin
          want = expQ.pop_front();
          got  = actQ.pop_front();
          if (want !== got) begin
            $display("error test %s: expected %h actual %h", testName(testId), want, got);
            addError();
          end
        end
      end

      if (stimFault) addError();

      if (testEnd) begin
        if (expQ.size() != 0) begin
          $display("test %s: %0d expected words never came out", testName(testId), expQ.size());
          addError();
        end
        if (actQ.size() != 0) begin
          $display("test %s: %0d output words came out with nothing expected",
                   testName(testId), actQ.size());
          addError();
        end
        if (inMsg.size() != 0) begin
          $display("test %s: input message left incomplete", testName(testId));
          addError();
        end
        expQ.delete();   // next test starts from an empty reference
        actQ.delete();
        testsRun++;
        if (testErrs != 0) testsFailed++;
        $display("test %s: %s with %0d errors", testName(testId),
                 (testErrs == 0) ? "passed" : "failed", testErrs);
        testErrs = 0;
      end
    end
  end

endmodule

//--- verification/tbTop.sv
`timescale 1ns/100ps

// drives the message queue while the checker watches the DUT ports
module tbTop;

  localparam int deqNever    = 0;   // consumer policies
  localparam int deqAlways   = 1;
  localparam int deqRandom   = 2;
  localparam int quietCycles = 16;  // emptyN low this long means drained

  logic             CLK;
  logic             reset;
  logic             clr;
  logic             enq;
  logic             deq;
  logic             fullN;
  logic             emptyN;
  msgPkg::msgWord_t dIn;
  msgPkg::msgWord_t dOut;
  logic             testEnd;     // one cycle pulse at the end of a test
  logic [2:0]       testId;      // test now running
  logic             stimFault;   // stimulus side check failed
  int               errCount;
  int               testsRun;
  int               testsFailed;
  int               seed;
  int               deqMode;
  logic             fillMode;    // test 3 is filling the queue
  logic             fullSeen;    // fullN fell while filling
  int               wordsSent;
  int               cycle = 0;

  clockGen u_clk (
    .CLK   (CLK),
    .reset (reset)
  );

  msgQueueTop u_dut (
    .CLK    (CLK),
    .reset  (reset),
    .clr    (clr),
    .enq    (enq),
    .dIn    (dIn),
    .fullN  (fullN),
    .deq    (deq),
    .dOut   (dOut),
    .emptyN (emptyN)
  );

  msgChecker u_chk (
    .CLK         (CLK),
    .reset       (reset),
    .clr         (clr),
    .enq         (enq),
    .dIn         (dIn),
    .fullN       (fullN),
    .deq         (deq),
    .dOut        (dOut),
    .emptyN      (emptyN),
    .testEnd     (testEnd),
    .testId      (testId),
    .stimFault   (stimFault),
    .errCount    (errCount),
    .testsRun    (testsRun),
    .testsFailed (testsFailed)
  );

  // consumer only ever pulses deq while emptyN is high
  always @(negedge CLK) begin : consumer
    logic [31:0] r;
    r = $random(seed);
    if (reset || deqMode == deqNever) deq = 1'b0;
    else if (deqMode == deqAlways) deq = emptyN;
    else deq = emptyN && r[0];   // coin flip per cycle
  end

  // watchdog limit grows with the words sent so far
  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (cycle > 2000 + 40 * wordsSent) begin
      $display("timeout: no finish after %0d cycles with %0d words sent", cycle, wordsSent);
      $display("Done: errors found");
      $finish;
    end
  end

  // one producer word after waiting for room
  task automatic putWord(input logic [31:0] w);
    int lowCycles;
    lowCycles = 0;
    while (!fullN) begin
      if (fillMode) begin
        lowCycles++;
        if (lowCycles >= 4) begin   // queue is really full so start draining
          fullSeen = 1'b1;
          fillMode = 1'b0;
          deqMode  = deqRandom;
        end
      end
      @(negedge CLK);
    end
    dIn.data = w;
    enq      = 1'b1;
    wordsSent++;
    @(negedge CLK);
    enq = 1'b0;   // next putWord may raise it again right away
  endtask

  // header plus nPay random payload words where nPay < len cuts the message short
  task automatic sendMsg(input logic [15:0] tag, input logic [7:0] op,
                         input logic [7:0] len, input int nPay);
    msgPkg::msgWord_t w;
    logic [31:0]      r;
    w.hdr.tag = tag;
    w.hdr.op  = op;
    w.hdr.len = len;
    putWord(w.data);
    for (int k = 0; k < nPay; k++) begin
      r = $random(seed);
      putWord(r);
    end
  endtask

  // random tag, op and length with sum ops only when allowed
  task automatic sendRandom(input logic allowSum, input int maxLen);
    logic [31:0] r;
    logic [31:0] t;
    logic [7:0]  op;
    int          len;
    r   = $random(seed);
    t   = $random(seed);
    len = int'(r[15:0]) % (maxLen + 1);
    op  = r[23:16];
    if (op == msgPkg::opSum) op = 8'd2;
    if (allowSum && r[24]) op = msgPkg::opSum;
    sendMsg(t[15:0], op, len[7:0], len);
  endtask

  // drain the output, then tell the checker the test is over
  task automatic endTest();
    int quiet;
    deqMode = deqAlways;
    quiet   = 0;
    while (quiet < quietCycles) begin
      @(negedge CLK);
      if (emptyN) quiet = 0;
      else quiet++;
    end
    testEnd = 1'b1;
    @(negedge CLK);
    testEnd = 1'b0;
  endtask

  initial begin
    seed      = 83022;
    enq       = 1'b0;
    dIn       = '0;
    clr       = 1'b0;
    deq       = 1'b0;
    deqMode   = deqNever;
    fillMode  = 1'b0;
    fullSeen  = 1'b0;
    wordsSent = 0;
    testEnd   = 1'b0;
    testId    = 3'd0;
    stimFault = 1'b0;
    @(negedge CLK);
    while (reset) @(negedge CLK);

    testId  = 3'd1;   // pass-through only
    deqMode = deqAlways;
    for (int i = 0; i < 12; i++) sendRandom(1'b0, 20);
    endTest();

    testId = 3'd2;   // sum messages with the length corners
    sendMsg(16'h0a00, msgPkg::opSum, 8'd0, 0);
    sendMsg(16'h0a01, msgPkg::opSum, 8'd1, 1);
    sendMsg(16'h0a02, msgPkg::opSum, 8'(msgPkg::maxSumLen), msgPkg::maxSumLen);
    sendMsg(16'h0a03, 8'd0, 8'd0, 0);
    for (int i = 0; i < 5; i++) begin
      sendMsg(16'h0b00 + 16'(i), msgPkg::opSum, 8'(7 * i + 3), 7 * i + 3);
    end
    endTest();

    testId   = 3'd3;   // stalled consumer then random drain
    deqMode  = deqNever;
    fillMode = 1'b1;
    for (int i = 0; i < 8; i++) sendMsg(16'h0c00 + 16'(i), 8'(i % 3), 8'd15, 15);
    fillMode = 1'b0;
    if (!fullSeen) begin
      $display("test backPressure: top-level fullN never fell with the consumer stalled");
      stimFault = 1'b1;
      @(negedge CLK);
      stimFault = 1'b0;
    end
    endTest();

    testId  = 3'd4;   // mixed traffic with a random consumer
    deqMode = deqRandom;
    for (int i = 0; i < 20; i++) sendRandom(1'b1, 40);
    endTest();

    testId  = 3'd5;   // clear in the middle of a sum message
    deqMode = deqNever;
    sendMsg(16'h0d00, msgPkg::opSum, 8'd10, 4);
    while (!emptyN) @(negedge CLK);   // partial message has reached the output
    clr = 1'b1;
    @(negedge CLK);
    clr     = 1'b0;
    deqMode = deqAlways;
    for (int i = 0; i < 6; i++) sendRandom(1'b1, 12);
    endTest();

    repeat (2) @(negedge CLK);   // checker prints its last test line
    $display("summary: %0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tb.f
common/msgPkg.sv
fifo/srlFifoD.sv
source/msgFramer.sv
source/msgQueueTop.sv
verification/clockGen.sv
verification/msgChecker.sv
verification/tbTop.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tbTop --Mdir obj_dir -f tb.f &&
obj_dir/VtbTop | tee /dev/stderr | grep -qx "Done: no errors" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
